//--- rtl/board_pkg.sv
// shared widths, register map and counter lengths for the board wrapper
// imported by the RTL blocks and the testbench

package board_pkg;

  // register port geometry
  localparam int unsigned REG_DATA_WIDTH = 32;
  localparam int unsigned REG_ADDR_WIDTH = 2;

  typedef logic [REG_DATA_WIDTH-1:0] reg_data_t;
  typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

  // word indices of the control registers
  localparam reg_addr_t REG_EXIT_VALID  = 2'd0;
  localparam reg_addr_t REG_EXIT_VALUE  = 2'd1;
  localparam reg_addr_t REG_BOOT_STRAPS = 2'd2;
  localparam reg_addr_t REG_SCRATCH     = 2'd3;

  // bit positions inside BOOT_STRAPS
  localparam int unsigned STRAP_BOOT_SELECT_BIT = 0;
  localparam int unsigned STRAP_EXEC_FLASH_BIT  = 1;
  localparam int unsigned STRAP_COUNT           = 2;

  // heartbeat length, short for simulation
  // the board build uses 27 to get a visible blink
  localparam int unsigned HB_COUNT_WIDTH = 8;

  typedef logic [HB_COUNT_WIDTH-1:0] hb_count_t;

  // release flops in the reset synchronizer
  localparam int unsigned RST_SYNC_STAGES = 2;

  // synchronizer depth for the strap pins
  localparam int unsigned STRAP_SYNC_STAGES = 2;

endpackage

//--- rtl/rst_sync.sv
// reset synchronizer for the board reset
// asserts the internal reset at once, releases it on a clock edge

`timescale 1ns/100ps

module rst_sync
  import board_pkg::*;
(
  input  logic clk_gen,
  input  logic rst_n,
  output logic rst_sync_n_o,
  output logic rst_led_o
);

  // release chain, ones shift in from the bottom
  logic [RST_SYNC_STAGES-1:0] sync_q;
  logic                       rst_sync_n;

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[RST_SYNC_STAGES-2:0], 1'b1};
    end
  end

  // last stage is the internal reset
  assign rst_sync_n = sync_q[RST_SYNC_STAGES-1];

  assign rst_sync_n_o = rst_sync_n;

  // LED lights once the core is out of reset
  assign rst_led_o = rst_sync_n;

endmodule

//--- rtl/heartbeat_led.sv
// free-running heartbeat counter
// top bit blinks the clock LED once reset has released

`timescale 1ns/100ps

module heartbeat_led
  import board_pkg::*;
(
  input  logic clk_gen,
  input  logic rst_n,
  output logic clk_led_o
);

  hb_count_t clk_count;

  // wraps silently at the top
  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      clk_count <= '0;
    end else begin
      clk_count <= clk_count + hb_count_t'(1);
    end
  end

  // MSB toggles every 2**(HB_COUNT_WIDTH-1) cycles
  assign clk_led_o = clk_count[HB_COUNT_WIDTH-1];

endmodule

//--- rtl/soc_ctrl_regs.sv
// system control registers: exit status, boot straps and scratch word
// plain strobe port, read data returns one cycle after the request

`timescale 1ns/100ps

module soc_ctrl_regs
  import board_pkg::*;
(
  input  logic      clk_gen,
  input  logic      rst_n,

  // host register port
  input  logic      reg_req_i,
  input  logic      reg_we_i,
  input  reg_addr_t reg_addr_i,
  input  reg_data_t reg_wdata_i,
  output reg_data_t reg_rdata_o,
  output logic      reg_rvalid_o,

  // board straps
  input  logic      boot_select_i,
  input  logic      execute_from_flash_i,

  // exit status
  output logic      exit_valid_o,
  output reg_data_t exit_value_o
);

  logic      wr_en;
  logic      rd_en;
  logic      wr_exit_valid;
  logic      wr_exit_value;
  logic      wr_scratch;

  logic      exit_valid_q;
  reg_data_t exit_value_q;
  reg_data_t scratch_q;

  logic [STRAP_SYNC_STAGES-1:0][STRAP_COUNT-1:0] strap_sync_q;
  logic [STRAP_COUNT-1:0]                        strap_pins;
  logic [STRAP_COUNT-1:0]                        straps;

  reg_data_t straps_word;
  reg_data_t rdata_d;
  reg_data_t rdata_q;
  logic      rvalid_q;

  // request decode
  assign wr_en = reg_req_i & reg_we_i;
  assign rd_en = reg_req_i & ~reg_we_i;

  assign wr_exit_valid = wr_en && (reg_addr_i == REG_EXIT_VALID);
  assign wr_exit_value = wr_en && (reg_addr_i == REG_EXIT_VALUE);
  assign wr_scratch    = wr_en && (reg_addr_i == REG_SCRATCH);

  // sticky until reset, writing 0 does nothing
  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      exit_valid_q <= 1'b0;
    end else if (wr_exit_valid && reg_wdata_i[0]) begin
      exit_valid_q <= 1'b1;
    end
  end

  // full exit value, bit 0 drives the exit pin
  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      exit_value_q <= '0;
    end else if (wr_exit_value) begin
      exit_value_q <= reg_wdata_i;
    end
  end

  always_ff @(posedge clk_gen) begin
    if (wr_scratch) begin
      scratch_q <= reg_wdata_i;
    end
  end

  // strap pins are asynchronous to clk_gen
  always_comb begin
    strap_pins                        = '0;
    strap_pins[STRAP_BOOT_SELECT_BIT] = boot_select_i;
    strap_pins[STRAP_EXEC_FLASH_BIT]  = execute_from_flash_i;
  end

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      strap_sync_q <= '0;
    end else begin
      strap_sync_q <= {strap_sync_q[STRAP_SYNC_STAGES-2:0], strap_pins};
    end
  end

  assign straps = strap_sync_q[STRAP_SYNC_STAGES-1];

  always_comb begin
    straps_word                  = '0;
    straps_word[STRAP_COUNT-1:0] = straps;
  end

  // read mux
  always_comb begin
    unique case (reg_addr_i)
      REG_EXIT_VALID:  rdata_d = reg_data_t'(exit_valid_q);
      REG_EXIT_VALUE:  rdata_d = exit_value_q;
      REG_BOOT_STRAPS: rdata_d = straps_word;
      REG_SCRATCH:     rdata_d = scratch_q;
      default:         rdata_d = '0;
    endcase
  end

  // one read in flight per cycle, no stall
  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd_en;
    end
  end

  always_ff @(posedge clk_gen) begin
    if (rd_en) begin
      rdata_q <= rdata_d;
    end
  end

  assign reg_rdata_o  = rdata_q;
  assign reg_rvalid_o = rvalid_q;

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule

//--- rtl/board_wrapper.sv
// board level of the evaluation design
// ties the reset synchronizer, heartbeat and control registers to the pins

`timescale 1ns/100ps

module board_wrapper
  import board_pkg::*;
(
  input  logic      clk_gen,
  input  logic      rst_n,

  // host register port, stands in for the processor bus
  input  logic      reg_req_i,
  input  logic      reg_we_i,
  input  reg_addr_t reg_addr_i,
  input  reg_data_t reg_wdata_i,
  output reg_data_t reg_rdata_o,
  output logic      reg_rvalid_o,

  input  logic      boot_select_i,
  input  logic      execute_from_flash_i,

  // LEDs and exit pins
  output logic      rst_led_o,
  output logic      clk_led_o,
  output logic      exit_valid_o,
  output logic      exit_value_o
);

  logic      rst_sync_n;
  reg_data_t exit_value;

  rst_sync rst_sync_i (
    .clk_gen      (clk_gen),
    .rst_n        (rst_n),
    .rst_sync_n_o (rst_sync_n),
    .rst_led_o    (rst_led_o)
  );

  heartbeat_led heartbeat_led_i (
    .clk_gen   (clk_gen),
    .rst_n     (rst_sync_n),
    .clk_led_o (clk_led_o)
  );

  soc_ctrl_regs soc_ctrl_regs_i (
    .clk_gen              (clk_gen),
    .rst_n                (rst_sync_n),
    .reg_req_i            (reg_req_i),
    .reg_we_i             (reg_we_i),
    .reg_addr_i           (reg_addr_i),
    .reg_wdata_i          (reg_wdata_i),
    .reg_rdata_o          (reg_rdata_o),
    .reg_rvalid_o         (reg_rvalid_o),
    .boot_select_i        (boot_select_i),
    .execute_from_flash_i (execute_from_flash_i),
    .exit_valid_o         (exit_valid_o),
    .exit_value_o         (exit_value)
  );

  // only bit 0 has a pin on the board
  assign exit_value_o = exit_value[0];

endmodule

//--- dv/board_wrapper_asserts.sv
// concurrent checks on the board wrapper pins
// bound into every board_wrapper instance

`timescale 1ns/100ps

module board_wrapper_asserts (
  input logic clk_gen,
  input logic rst_n,
  input logic rst_sync_n_i,
  input logic reg_req_i,
  input logic reg_we_i,
  input logic reg_rvalid_i,
  input logic rst_led_i,
  input logic clk_led_i,
  input logic exit_valid_i,
  input logic exit_value_i
);

  logic rd_req;
  logic wr_req;

  assign rd_req = reg_req_i & ~reg_we_i;
  assign wr_req = reg_req_i & reg_we_i;

  rvalid_after_read: assert property (@(posedge clk_gen) disable iff (!rst_sync_n_i)
    rd_req |=> reg_rvalid_i)
    else $error("reg_rvalid_o missing one cycle after a read request");

  // sticky flag
  exit_valid_holds: assert property (@(posedge clk_gen) disable iff (!rst_sync_n_i)
    !$fell(exit_valid_i))
    else $error("exit_valid_o fell while out of reset");

  outputs_low_in_reset: assert property (@(posedge clk_gen)
    !rst_n |-> !(rst_led_i | clk_led_i | exit_valid_i | exit_value_i | reg_rvalid_i))
    else $error("an output is high while the board reset is held");

  no_rvalid_after_write: assert property (@(posedge clk_gen) disable iff (!rst_sync_n_i)
    wr_req |=> !reg_rvalid_i)
    else $error("reg_rvalid_o followed a write request");

endmodule

bind board_wrapper board_wrapper_asserts board_wrapper_asserts_i (
  .clk_gen      (clk_gen),
  .rst_n        (rst_n),
  .rst_sync_n_i (rst_sync_n),
  .reg_req_i    (reg_req_i),
  .reg_we_i     (reg_we_i),
  .reg_rvalid_i (reg_rvalid_o),
  .rst_led_i    (rst_led_o),
  .clk_led_i    (clk_led_o),
  .exit_valid_i (exit_valid_o),
  .exit_value_i (exit_value_o)
);

//--- dv/tb_board_wrapper.sv
// testbench for the board wrapper
// checks reset and heartbeat timing, then applies a table of register accesses

`timescale 1ns/100ps

module tb_board_wrapper
  import board_pkg::*;
();

  localparam int NUM_ENTRIES    = 20;
  localparam int RESET_CYCLES   = 10;
  localparam int RELEASE_CYCLES = 2;
  localparam int HB_CYCLES      = 300;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + RELEASE_CYCLES + HB_CYCLES
                                  + 2 * NUM_ENTRIES + 50;
  // LED toggles every half period of the counter
  localparam int HB_HALF        = 1 << (HB_COUNT_WIDTH - 1);

  localparam int OP_IDLE  = 0;
  localparam int OP_WRITE = 1;
  localparam int OP_READ  = 2;

  logic      clk_gen;
  logic      rst_n;
  logic      reg_req;
  logic      reg_we;
  reg_addr_t reg_addr;
  reg_data_t reg_wdata;
  reg_data_t reg_rdata;
  logic      reg_rvalid;
  logic      boot_select;
  logic      execute_from_flash;
  logic      rst_led;
  logic      clk_led;
  logic      exit_valid;
  logic      exit_value;

  // stimulus table, one entry per cycle
  string     names[NUM_ENTRIES];
  int        ops[NUM_ENTRIES];
  reg_addr_t addrs[NUM_ENTRIES];
  reg_data_t wdatas[NUM_ENTRIES];
  reg_data_t exp_rdatas[NUM_ENTRIES];
  logic      exp_valids[NUM_ENTRIES];
  logic      exp_values[NUM_ENTRIES];

  integer    seed;
  int        cycle_count = 0;
  reg_data_t scratch_a;
  reg_data_t scratch_b;
  reg_data_t exit_odd;
  reg_data_t exit_even;

  board_wrapper dut_i (
    .clk_gen              (clk_gen),
    .rst_n                (rst_n),
    .reg_req_i            (reg_req),
    .reg_we_i             (reg_we),
    .reg_addr_i           (reg_addr),
    .reg_wdata_i          (reg_wdata),
    .reg_rdata_o          (reg_rdata),
    .reg_rvalid_o         (reg_rvalid),
    .boot_select_i        (boot_select),
    .execute_from_flash_i (execute_from_flash),
    .rst_led_o            (rst_led),
    .clk_led_o            (clk_led),
    .exit_valid_o         (exit_valid),
    .exit_value_o         (exit_value)
  );

  always #5 clk_gen = ~clk_gen;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  always @(posedge clk_gen) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("timeout after %0d cycles, the run did not finish", cycle_count));
    end
  end

  task automatic check_word(input string name, input reg_data_t expected,
                            input reg_data_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("FAILED %s expected %b actual %b", name, expected, actual));
    end
  endtask

  task automatic check_reset_outputs(input string name, input logic exp_rst_led);
    check_bit({name, " rst_led_o"}, exp_rst_led, rst_led);
    check_bit({name, " exit_valid_o"}, 1'b0, exit_valid);
    check_bit({name, " exit_value_o"}, 1'b0, exit_value);
    check_bit({name, " reg_rvalid_o"}, 1'b0, reg_rvalid);
    check_bit({name, " clk_led_o"}, 1'b0, clk_led);
  endtask

  task automatic set_entry(input int idx, input string name, input int op,
                           input reg_addr_t addr, input reg_data_t wdata,
                           input reg_data_t exp_rdata, input logic exp_valid,
                           input logic exp_value);
    names[idx]      = name;
    ops[idx]        = op;
    addrs[idx]      = addr;
    wdatas[idx]     = wdata;
    exp_rdatas[idx] = exp_rdata;
    exp_valids[idx] = exp_valid;
    exp_values[idx] = exp_value;
  endtask

  // expected exit state is the state after that entry's edge
  task automatic build_table();
    set_entry(0, "idle_start", OP_IDLE, REG_EXIT_VALID, '0, '0, 1'b0, 1'b0);
    set_entry(1, "write_scratch_a", OP_WRITE, REG_SCRATCH, scratch_a, '0, 1'b0, 1'b0);
    set_entry(2, "read_scratch_a", OP_READ, REG_SCRATCH, '0, scratch_a, 1'b0, 1'b0);
    set_entry(3, "write_exit_odd", OP_WRITE, REG_EXIT_VALUE, exit_odd, '0, 1'b0, 1'b1);
    set_entry(4, "read_exit_odd", OP_READ, REG_EXIT_VALUE, '0, exit_odd, 1'b0, 1'b1);
    set_entry(5, "write_scratch_b", OP_WRITE, REG_SCRATCH, scratch_b, '0, 1'b0, 1'b1);
    // back-to-back reads from here
    set_entry(6, "read_scratch_b", OP_READ, REG_SCRATCH, '0, scratch_b, 1'b0, 1'b1);
    set_entry(7, "read_exit_again", OP_READ, REG_EXIT_VALUE, '0, exit_odd, 1'b0, 1'b1);
    set_entry(8, "read_scratch_b_2", OP_READ, REG_SCRATCH, '0, scratch_b, 1'b0, 1'b1);
    set_entry(9, "read_straps", OP_READ, REG_BOOT_STRAPS, '0, 32'd1, 1'b0, 1'b1);
    set_entry(10, "write_straps", OP_WRITE, REG_BOOT_STRAPS, '1, '0, 1'b0, 1'b1);
    set_entry(11, "read_straps_2", OP_READ, REG_BOOT_STRAPS, '0, 32'd1, 1'b0, 1'b1);
    set_entry(12, "read_valid_0", OP_READ, REG_EXIT_VALID, '0, 32'd0, 1'b0, 1'b1);
    set_entry(13, "set_valid", OP_WRITE, REG_EXIT_VALID, 32'd1, '0, 1'b1, 1'b1);
    set_entry(14, "read_valid_1", OP_READ, REG_EXIT_VALID, '0, 32'd1, 1'b1, 1'b1);
    set_entry(15, "clear_valid", OP_WRITE, REG_EXIT_VALID, 32'd0, '0, 1'b1, 1'b1);
    set_entry(16, "read_valid_sticky", OP_READ, REG_EXIT_VALID, '0, 32'd1, 1'b1, 1'b1);
    set_entry(17, "write_exit_even", OP_WRITE, REG_EXIT_VALUE, exit_even, '0, 1'b1, 1'b0);
    set_entry(18, "read_exit_even", OP_READ, REG_EXIT_VALUE, '0, exit_even, 1'b1, 1'b0);
    set_entry(19, "idle_end", OP_IDLE, REG_EXIT_VALID, '0, '0, 1'b1, 1'b0);
  endtask

  task automatic drive_entry(input int idx);
    reg_req   = (ops[idx] != OP_IDLE);
    reg_we    = (ops[idx] == OP_WRITE);
    reg_addr  = addrs[idx];
    reg_wdata = wdatas[idx];
  endtask

  task automatic drive_idle();
    reg_req   = 1'b0;
    reg_we    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
  endtask

  task automatic check_entry(input int idx);
    check_bit({names[idx], " exit_valid_o"}, exp_valids[idx], exit_valid);
    check_bit({names[idx], " exit_value_o"}, exp_values[idx], exit_value);
    if (ops[idx] == OP_READ) begin
      if (reg_rvalid !== 1'b1) begin
        abort_run($sformatf("read %s got no reg_rvalid_o on the following edge",
                            names[idx]));
      end else begin
        check_word({names[idx], " reg_rdata_o"}, exp_rdatas[idx], reg_rdata);
      end
    end else begin
      check_bit({names[idx], " reg_rvalid_o"}, 1'b0, reg_rvalid);
    end
  endtask

  initial begin
    clk_gen            = 1'b0;
    rst_n              = 1'b1;
    boot_select        = 1'b0;
    execute_from_flash = 1'b0;
    drive_idle();
    seed      = 11672;
    scratch_a = $random(seed);
    scratch_b = $random(seed);
    exit_odd  = $random(seed) | 32'd1;
    exit_even = $random(seed) & ~32'd1;
    build_table();

    #1 rst_n = 1'b0;
    repeat (RESET_CYCLES) begin
      @(negedge clk_gen);
      check_reset_outputs("reset_held", 1'b0);
    end
    rst_n = 1'b1;
    @(negedge clk_gen);
    check_reset_outputs("release_edge_1", 1'b0);
    @(negedge clk_gen);
    check_reset_outputs("release_edge_2", 1'b1);

    // edge 0 is the one that released the internal reset
    for (int i = 1; i <= 2 * HB_HALF; i++) begin
      @(negedge clk_gen);
      check_bit($sformatf("heartbeat_edge_%0d", i), (i >= HB_HALF) && (i < 2 * HB_HALF),
                clk_led);
    end

    boot_select        = 1'b1;
    execute_from_flash = 1'b0;
    for (int i = 0; i <= NUM_ENTRIES; i++) begin
      @(negedge clk_gen);
      if (i > 0) begin
        check_entry(i - 1);
      end
      if (i < NUM_ENTRIES) begin
        drive_entry(i);
      end else begin
        drive_idle();
      end
    end

    $display("TEST OK");
    $finish;
  end

endmodule

//--- all.f
rtl/board_pkg.sv
rtl/rst_sync.sv
rtl/heartbeat_led.sv
rtl/soc_ctrl_regs.sv
rtl/board_wrapper.sv
dv/board_wrapper_asserts.sv
dv/tb_board_wrapper.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the board wrapper testbench with Verilator and runs it.
# Exits with status 0 only when the testbench prints its pass line.

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_board_wrapper
BUILD_DIR=obj_dir

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --assert -j 0 \
  --top-module "${TOP}" \
  --Mdir "${BUILD_DIR}" \
  -f all.f
build_status=$?
if [ ${build_status} -ne 0 ]; then
  echo "build failed with status ${build_status}"
  exit 1
fi

sim_output=$("./${BUILD_DIR}/V${TOP}" 2>&1)
sim_status=$?
echo "${sim_output}"

if [ ${sim_status} -ne 0 ]; then
  echo "simulation exited with status ${sim_status}"
  exit 1
fi

if grep -qx "TEST OK" <<< "${sim_output}"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation did not report a pass"
  exit 1
fi
